// ==== rtl/fifo_pkg.sv ====
package fifo_pkg;

  // word and storage size
  localparam int DATA_W = 8;
  localparam int DEPTH  = 16;

  localparam int ADDR_W = $clog2(DEPTH);
  localparam int PTR_W  = ADDR_W + 1;  // extra bit tells full from empty

  // status thresholds in words
  localparam int AFULL_LVL  = 15;
  localparam int AEMPTY_LVL = 1;

  typedef logic [DATA_W-1:0] data_t;

  typedef logic [ADDR_W-1:0] addr_t;

  // binary or gray, with wrap bit
  typedef logic [PTR_W-1:0] ptr_t;

  // write side flags
  typedef struct packed {
    logic full;
    logic afull;
  } wr_status_t;

  // read side flags
  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_status_t;

endpackage

// ==== rtl/dual_port_ram.sv ====
module dual_port_ram (
  input  logic            wr_clk,
  input  logic            wr_en,
  input  fifo_pkg::addr_t wr_addr,
  input  fifo_pkg::data_t wr_data,

  input  logic            rd_clk,
  input  logic            rd_en,
  input  fifo_pkg::addr_t rd_addr,
  output fifo_pkg::data_t rd_data
);

  fifo_pkg::data_t mem [fifo_pkg::DEPTH];

  // write port, wr_clk domain
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read port
  // rd_data holds its last word while rd_en is low
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== rtl/gray_ptr_sync.sv ====
module gray_ptr_sync (
  input  logic           src_clk,
  input  logic           src_rst_n,
  input  fifo_pkg::ptr_t src_ptr,

  input  logic           dst_clk,
  input  logic           dst_rst_n,
  output fifo_pkg::ptr_t dst_ptr
);

  fifo_pkg::ptr_t src_gray;
  fifo_pkg::ptr_t src_gray_q;  // launch flop, glitch free
  fifo_pkg::ptr_t sync_q1;
  fifo_pkg::ptr_t sync_q2;

  // binary to gray, one bit changes per increment
  assign src_gray = src_ptr ^ (src_ptr >> 1);

  always_ff @(posedge src_clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      src_gray_q <= '0;
    end else begin
      src_gray_q <= src_gray;
    end
  end

  // two flop synchronizer in the destination domain
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= src_gray_q;
      sync_q2 <= sync_q1;
    end
  end

  // gray back to binary
  // each bit is the xor of all gray bits above and at it
  always_comb begin
    dst_ptr[fifo_pkg::PTR_W-1] = sync_q2[fifo_pkg::PTR_W-1];
    for (int i = fifo_pkg::PTR_W - 2; i >= 0; i--) begin
      dst_ptr[i] = dst_ptr[i+1] ^ sync_q2[i];
    end
  end

endmodule

// ==== rtl/fifo_wr_ctrl.sv ====
module fifo_wr_ctrl (
  input  logic                 wr_clk,
  input  logic                 wr_rst_n,
  input  logic                 wr_en,
  input  fifo_pkg::ptr_t       rd_ptr_wr,  // read pointer, already synced

  output logic                 wr_accept,
  output fifo_pkg::ptr_t       wr_ptr,
  output fifo_pkg::wr_status_t wr_status
);

  fifo_pkg::ptr_t wr_ptr_nxt;
  fifo_pkg::ptr_t level_nxt;
  logic           full_nxt;
  logic           afull_nxt;

  // writes while full are dropped
  assign wr_accept = wr_en & ~wr_status.full;

  always_comb begin
    wr_ptr_nxt = wr_ptr;
    if (wr_accept) begin
      wr_ptr_nxt = wr_ptr + fifo_pkg::ptr_t'(1);
    end
  end

  // fill level seen from the write side
  // the synced read pointer lags, so this never underestimates
  assign level_nxt = wr_ptr_nxt - rd_ptr_wr;

  assign full_nxt  = (level_nxt == fifo_pkg::ptr_t'(fifo_pkg::DEPTH));
  assign afull_nxt = (level_nxt >= fifo_pkg::ptr_t'(fifo_pkg::AFULL_LVL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr_nxt;
    end
  end

  // flags valid the cycle after the accepting edge
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_status.full  <= 1'b0;
      wr_status.afull <= 1'b0;
    end else begin
      wr_status.full  <= full_nxt;
      wr_status.afull <= afull_nxt;
    end
  end

endmodule

// ==== rtl/fifo_rd_ctrl.sv ====
module fifo_rd_ctrl (
  input  logic                 rd_clk,
  input  logic                 rd_rst_n,
  input  logic                 rd_en,
  input  fifo_pkg::ptr_t       wr_ptr_rd,  // write pointer, already synced

  output logic                 rd_accept,
  output fifo_pkg::ptr_t       rd_ptr,
  output logic                 rd_valid,
  output fifo_pkg::rd_status_t rd_status
);

  fifo_pkg::ptr_t rd_ptr_nxt;
  fifo_pkg::ptr_t level_nxt;
  logic           empty_nxt;
  logic           aempty_nxt;

  // reads while empty do nothing
  assign rd_accept = rd_en & ~rd_status.empty;

  always_comb begin
    rd_ptr_nxt = rd_ptr;
    if (rd_accept) begin
      rd_ptr_nxt = rd_ptr + fifo_pkg::ptr_t'(1);
    end
  end

  // words left as seen from the read side
  assign level_nxt = wr_ptr_rd - rd_ptr_nxt;

  assign empty_nxt  = (level_nxt == '0);
  assign aempty_nxt = (level_nxt <= fifo_pkg::ptr_t'(fifo_pkg::AEMPTY_LVL));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr <= '0;
    end else begin
      rd_ptr <= rd_ptr_nxt;
    end
  end

  // ram output lands one rd_clk later
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_accept;
    end
  end

  // reset as empty so nothing is read before the first write crosses
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_status.empty  <= 1'b1;
      rd_status.aempty <= 1'b1;
    end else begin
      rd_status.empty  <= empty_nxt;
      rd_status.aempty <= aempty_nxt;
    end
  end

endmodule

// ==== rtl/async_fifo.sv ====
module async_fifo (
  input  logic                 wr_clk,
  input  logic                 wr_rst_n,
  input  logic                 wr_en,
  input  fifo_pkg::data_t      wr_data,
  output fifo_pkg::wr_status_t wr_status,

  input  logic                 rd_clk,
  input  logic                 rd_rst_n,
  input  logic                 rd_en,
  output fifo_pkg::data_t      rd_data,
  output logic                 rd_valid,
  output fifo_pkg::rd_status_t rd_status
);

  logic           wr_accept;
  fifo_pkg::ptr_t wr_ptr;
  fifo_pkg::ptr_t rd_ptr_wr;  // rd_ptr in wr_clk domain

  logic           rd_accept;
  fifo_pkg::ptr_t rd_ptr;
  fifo_pkg::ptr_t wr_ptr_rd;  // wr_ptr in rd_clk domain

  fifo_wr_ctrl wr_ctrl (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .rd_ptr_wr (rd_ptr_wr),
    .wr_accept (wr_accept),
    .wr_ptr    (wr_ptr),
    .wr_status (wr_status)
  );

  fifo_rd_ctrl rd_ctrl (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .wr_ptr_rd (wr_ptr_rd),
    .rd_accept (rd_accept),
    .rd_ptr    (rd_ptr),
    .rd_valid  (rd_valid),
    .rd_status (rd_status)
  );

  // write to read crossing
  gray_ptr_sync wsync (
    .src_clk   (wr_clk),
    .src_rst_n (wr_rst_n),
    .src_ptr   (wr_ptr),
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .dst_ptr   (wr_ptr_rd)
  );

  // read to write crossing
  gray_ptr_sync rsync (
    .src_clk   (rd_clk),
    .src_rst_n (rd_rst_n),
    .src_ptr   (rd_ptr),
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .dst_ptr   (rd_ptr_wr)
  );

  // addresses drop the wrap bit
  dual_port_ram ram (
    .wr_clk  (wr_clk),
    .wr_en   (wr_accept),
    .wr_addr (wr_ptr[fifo_pkg::ADDR_W-1:0]),
    .wr_data (wr_data),
    .rd_clk  (rd_clk),
    .rd_en   (rd_accept),
    .rd_addr (rd_ptr[fifo_pkg::ADDR_W-1:0]),
    .rd_data (rd_data)
  );

endmodule

// ==== sim/async_fifo_sva.sv ====
module async_fifo_sva (
  input logic                 wr_clk,
  input logic                 wr_rst_n,
  input logic                 rd_clk,
  input logic                 rd_rst_n,
  input fifo_pkg::wr_status_t wr_status,
  input fifo_pkg::rd_status_t rd_status,
  input logic                 rd_en,
  input logic                 rd_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  full_implies_afull: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
      wr_status.full |-> wr_status.afull
  ) else $error("full set while afull is low");

  empty_implies_aempty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
      rd_status.empty |-> rd_status.aempty
  ) else $error("empty set while aempty is low");

  // read strobe on an empty FIFO is dropped
  no_valid_on_underflow: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
      (rd_en && rd_status.empty) |=> !rd_valid
  ) else $error("rd_valid after a read while empty");

  // a read counts only when the strobe met a non-empty FIFO
  back_to_back_valid: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
      (rd_valid && $past(rd_valid)) |->
        ($past(rd_en && !rd_status.empty) && $past(rd_en && !rd_status.empty, 2))
  ) else $error("rd_valid held without two accepted reads");

endmodule

// ==== sim/async_fifo_tb.sv ====
module async_fifo_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WR_PERIOD      = 4;
  localparam int RD_PERIOD      = 6;
  localparam int MAX_CASES      = 64;
  localparam int SETTLE_CYCLES  = 8;  // rd_clk cycles, the slower clock
  localparam int FLAG_TIMEOUT   = 20;
  localparam int STREAM_TIMEOUT = 4000;

  logic                 wr_clk;
  logic                 wr_rst_n;
  logic                 wr_en;
  fifo_pkg::data_t      wr_data;
  fifo_pkg::wr_status_t wr_status;
  logic                 rd_clk;
  logic                 rd_rst_n;
  logic                 rd_en;
  fifo_pkg::data_t      rd_data;
  logic                 rd_valid;
  fifo_pkg::rd_status_t rd_status;

  fifo_pkg::data_t model_q [$];  // words the DUT accepted, oldest first
  logic [15:0]     cases [MAX_CASES];
  int              wr_acc_cnt = 0;
  int              rd_acc_cnt = 0;
  int              n_checks = 0;
  int              n_errors = 0;

  async_fifo dut0 (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .wr_status (wr_status),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .rd_status (rd_status)
  );

  bind async_fifo async_fifo_sva sva0 (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .wr_status (wr_status),
    .rd_status (rd_status),
    .rd_en     (rd_en),
    .rd_valid  (rd_valid)
  );

  initial begin
    wr_clk = 1'b0;
    forever #(WR_PERIOD / 2) wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #(RD_PERIOD / 2) rd_clk = ~rd_clk;
  end

  // write is taken when full was low at the edge
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !wr_status.full) begin
      model_q.push_back(wr_data);
      wr_acc_cnt++;
    end
  end

  always @(posedge rd_clk) begin : read_monitor
    fifo_pkg::data_t exp_word;
    if (rd_rst_n && rd_en && !rd_status.empty) begin
      rd_acc_cnt++;
    end
    if (rd_valid) begin
      n_checks++;
      if (model_q.size() == 0) begin
        n_errors++;
        $display("%0t: rd_valid high with no word left in the model", $time);
      end else begin
        exp_word = model_q.pop_front();
        if (rd_data !== exp_word) begin
          n_errors++;
          $display("FAIL %0t rd_data expected %h got %h", $time, exp_word, rd_data);
        end
      end
    end
  end

  task automatic wr_cycle();
    @(posedge wr_clk);
    #0.5;
  endtask

  task automatic rd_cycle();
    @(posedge rd_clk);
    #0.5;
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // {full, afull, empty, aempty}
  task automatic check_flags(input logic [3:0] exp);
    check_bit("wr_status.full", exp[3], wr_status.full);
    check_bit("wr_status.afull", exp[2], wr_status.afull);
    check_bit("rd_status.empty", exp[1], rd_status.empty);
    check_bit("rd_status.aempty", exp[0], rd_status.aempty);
  endtask

  function automatic logic [3:0] flags_for_level(input int cnt);
    flags_for_level = {cnt == fifo_pkg::DEPTH, cnt >= fifo_pkg::AFULL_LVL,
                       cnt == 0, cnt <= fifo_pkg::AEMPTY_LVL};
  endfunction

  task automatic wait_empty_fall();
    int t;
    t = 0;
    while (rd_status.empty && t < FLAG_TIMEOUT) begin
      rd_cycle();
      t++;
    end
    n_checks++;
    if (rd_status.empty) begin
      n_errors++;
      $display("%0t: empty stayed high after a write into an empty FIFO", $time);
    end
  endtask

  task automatic wait_full_fall();
    int t;
    t = 0;
    while (wr_status.full && t < FLAG_TIMEOUT) begin
      wr_cycle();
      t++;
    end
    n_checks++;
    if (wr_status.full) begin
      n_errors++;
      $display("%0t: full stayed high after a read from a full FIFO", $time);
    end
  endtask

  task automatic write_burst(input int n);
    logic was_empty;
    was_empty = (model_q.size() == 0);
    for (int i = 0; i < n; i++) begin
      wr_cycle();
      wr_en   = 1'b1;
      wr_data = fifo_pkg::data_t'($urandom);
    end
    wr_cycle();
    wr_en = 1'b0;
    if (was_empty && n > 0) begin
      wait_empty_fall();
    end
  endtask

  task automatic read_burst(input int n);
    logic was_full;
    was_full = wr_status.full;
    for (int i = 0; i < n; i++) begin
      rd_cycle();
      rd_en = 1'b1;
    end
    rd_cycle();
    rd_en = 1'b0;
    if (was_full && n > 0) begin
      wait_full_fall();
    end
  endtask

  // random strobes until target words were taken
  task automatic stream_writes(input int target);
    int t;
    t = 0;
    wr_cycle();
    while (wr_acc_cnt < target && t < STREAM_TIMEOUT) begin
      wr_en   = 1'($urandom % 2);
      wr_data = fifo_pkg::data_t'($urandom);
      wr_cycle();
      t++;
    end
    wr_en = 1'b0;
    if (wr_acc_cnt < target) begin
      n_errors++;
      $display("%0t: write stream timed out", $time);
    end
  endtask

  task automatic stream_reads(input int target);
    int t;
    t = 0;
    rd_cycle();
    while (rd_acc_cnt < target && t < STREAM_TIMEOUT) begin
      rd_en = 1'($urandom % 2);
      rd_cycle();
      t++;
    end
    rd_en = 1'b0;
    if (rd_acc_cnt < target) begin
      n_errors++;
      $display("%0t: read stream timed out", $time);
    end
  endtask

  task automatic run_stream(input int n);
    int wr_target;
    int rd_target;
    wr_target = wr_acc_cnt + n;
    rd_target = rd_acc_cnt + n;
    fork
      stream_writes(wr_target);
      stream_reads(rd_target);
    join
  endtask

  initial begin
    logic [3:0] op;
    logic [3:0] exp_flags;
    int         n;
    void'($urandom(84));
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    for (int i = 0; i < MAX_CASES; i++) begin
      cases[i] = 16'hf000;
    end
    $readmemh("sim/fifo_cases.txt", cases);

    fork
      begin
        repeat (2) @(posedge wr_clk);
        #0.5;
        wr_rst_n = 1'b1;
      end
      begin
        repeat (2) @(posedge rd_clk);
        #0.5;
        rd_rst_n = 1'b1;
      end
    join
    rd_cycle();
    check_bit("rd_valid", 1'b0, rd_valid);
    check_flags(4'b0011);

    if (cases[0][15:12] == 4'hf) begin
      n_errors++;
      $display("no operations found in sim/fifo_cases.txt");
    end
    for (int i = 0; i < MAX_CASES; i++) begin
      op        = cases[i][15:12];
      n         = int'(cases[i][11:4]);
      exp_flags = cases[i][3:0];
      if (op == 4'hf) begin
        break;
      end
      case (op)
        4'h0: repeat (n) rd_cycle();
        4'h1: write_burst(n);
        4'h2: read_burst(n);
        4'h3: run_stream(n);
        default: begin
          n_errors++;
          $display("unknown operation %h on case line %0d", op, i);
        end
      endcase
      repeat (SETTLE_CYCLES) rd_cycle();
      n_checks++;
      if (model_q.size() > fifo_pkg::DEPTH) begin
        n_errors++;
        $display("FAIL %0t stored words expected at most %0d got %0d", $time,
                 fifo_pkg::DEPTH, model_q.size());
      end
      check_flags(exp_flags);
      check_flags(flags_for_level(model_q.size()));
    end

    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== sim/fifo_cases.txt ====
// each line is op_count_flags in hex, count in words or cycles
// op 0 idle, 1 write burst, 2 read burst, 3 random stream, f end
// flags are full afull empty aempty from the msb down
0_0a_3  // idle after reset
2_04_3  // reads while empty
1_01_1
2_03_3
1_14_c  // 20 writes, 4 dropped
2_01_4
1_03_c
2_14_3  // drain, extra reads ignored
1_02_0
1_0d_4
2_0e_1
2_01_3
1_05_0
3_3c_0
2_05_3
3_28_3
1_10_c
3_1e_c  // stream with writes blocked at first
2_0f_1
0_05_1
2_02_3
f_00_0

// ==== all.f ====
rtl/fifo_pkg.sv
rtl/dual_port_ram.sv
rtl/gray_ptr_sync.sv
rtl/fifo_wr_ctrl.sv
rtl/fifo_rd_ctrl.sv
rtl/async_fifo.sv
sim/async_fifo_sva.sv
sim/async_fifo_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = async_fifo_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
PASS_MSG = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# output is shown and searched in memory
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
